/* Bender.yml */
package:
  name: cpu_top

sources:
  - cpuPkg.sv
  - regFile.sv
  - busMux.sv
  - alu.sv
  - dataPath.sv
  - controlSequencer.sv
  - cpuTop.sv
  - target: simulation
    files:
      - tbCpuTop.sv

/* alu.sv */
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  opcodeT aluOp,
    input  logic   incPc,
    input  wordT   y,
    input  wordT   b,
    output wordT   zHigh,
    output wordT   zLow
);

    logic [2*WordWidth-1:0] wide;
    logic [2*WordWidth-1:0] ySext;
    logic [2*WordWidth-1:0] bSext;
    shiftT                  shAmt;

    assign ySext = {{WordWidth{y[WordWidth-1]}}, y};
    assign bSext = {{WordWidth{b[WordWidth-1]}}, b};
    assign shAmt = shiftT'(b); // low five bits of rc

    always_comb begin
        wide = '0;
        if (incPc) begin
            wide = {{WordWidth{1'b0}}, b + wordT'(1)}; // pc increment path
        end else begin
            case (aluOp)
                add:     wide = ySext + bSext;
                sub:     wide = ySext - bSext;
                andOp:   wide = {{WordWidth{1'b0}}, y & b};
                orOp:    wide = {{WordWidth{1'b0}}, y | b};
                shl:     wide = {{WordWidth{1'b0}}, y << shAmt};
                shr:     wide = {{WordWidth{1'b0}}, y >> shAmt}; // logical shift
                neg:     wide = {{WordWidth{1'b0}}, wordT'(-b)};
                notOp:   wide = {{WordWidth{1'b0}}, ~b};
                default: wide = '0;
            endcase
        end
    end

    assign zHigh = wide[2*WordWidth-1:WordWidth];
    assign zLow  = wide[WordWidth-1:0];

endmodule

`default_nettype wire

/* busMux.sv */
`default_nettype none

module busMux
    import cpuPkg::*;
(
    input  busSrcT busSrc,
    input  wordT   pc,
    input  wordT   mdr,
    input  wordT   zLow,
    input  wordT   gpr,
    output wordT   bus
);

    // one encoded source in place of a separate out strobe per register
    always_comb begin
        case (busSrc)
            srcPc: begin
                bus = pc;
            end
            srcMdr: begin
                bus = mdr;
            end
            srcZLow: begin
                bus = zLow;
            end
            srcGpr: begin
                bus = gpr; // register picked by regSel
            end
            default: begin
                bus = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* controlSequencer.sv */
`default_nettype none

module controlSequencer
    import cpuPkg::*;
(
    input  logic Clock,
    input  logic rstN,
    input  logic start,
    input  wordT irWord,
    output ctrlT ctrl,
    output logic done
);

    stepT   step;
    stepT   stepNext;
    opcodeT op;
    regIdxT ra;
    regIdxT rb;
    regIdxT rc;
    logic   isAlu;

    assign op = opcodeT'(irWord[OpMsb -: OpWidth]);
    assign ra = irWord[RaMsb -: $bits(regIdxT)];
    assign rb = irWord[RbMsb -: $bits(regIdxT)];
    assign rc = irWord[RcMsb -: $bits(regIdxT)];
    assign isAlu = op inside {add, sub, andOp, orOp, shl, shr, neg, notOp};

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            step <= idle;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        case (step)
            idle:    stepNext = start ? t0 : idle; // start ignored once running
            t0:      stepNext = t1;
            t1:      stepNext = t2;
            t2:      stepNext = t3;
            t3:      stepNext = t4;
            t4:      stepNext = t5;
            default: stepNext = idle;
        endcase
    end

    // fetch in t0 to t2, then ir decides the execute steps
    always_comb begin
        ctrl = '0;
        case (step)
            t0: begin
                ctrl.busSrc  = srcPc;
                ctrl.marLoad = 1'b1;
                ctrl.incPc   = 1'b1;
                ctrl.zLoad   = 1'b1;
            end
            t1: begin
                ctrl.busSrc  = srcZLow;
                ctrl.pcLoad  = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrLoad = 1'b1;
            end
            t2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irLoad = 1'b1;
            end
            t3: begin
                if (isAlu) begin
                    ctrl.busSrc = srcGpr;
                    ctrl.regSel = rb;
                    ctrl.yLoad  = 1'b1;
                end else if (op == ldw) begin
                    ctrl.busSrc  = srcPc; // inline word sits at pc
                    ctrl.marLoad = 1'b1;
                    ctrl.incPc   = 1'b1;
                    ctrl.zLoad   = 1'b1;
                end else if (op == outp) begin
                    ctrl.busSrc  = srcGpr;
                    ctrl.regSel  = ra;
                    ctrl.outLoad = 1'b1;
                end
            end
            t4: begin
                if (isAlu) begin
                    ctrl.busSrc = srcGpr;
                    ctrl.regSel = rc;
                    ctrl.zLoad  = 1'b1;
                    ctrl.aluOp  = op;
                end else if (op == ldw) begin
                    ctrl.busSrc  = srcZLow; // pc skips past the inline word
                    ctrl.pcLoad  = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.mdrLoad = 1'b1;
                end
            end
            t5: begin
                if (isAlu || op == ldw) begin
                    ctrl.busSrc  = isAlu ? srcZLow : srcMdr;
                    ctrl.regSel  = ra;
                    ctrl.gprLoad = 1'b1;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign done = (step == t5);

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int WordWidth = 32;
    localparam int NumRegs   = 16;
    localparam int OpWidth   = 5;

    // instruction layout, each field counted down from its msb
    localparam int OpMsb = 31; // opcode in 31:27
    localparam int RaMsb = 26; // destination in 26:23
    localparam int RbMsb = 22; // first source in 22:19
    localparam int RcMsb = 18; // second source in 18:15

    typedef logic [WordWidth-1:0]       wordT;
    typedef logic [$clog2(NumRegs)-1:0] regIdxT;
    typedef logic [4:0]                 shiftT; // shift amount from the low bits of rc

    // names that clash with keywords carry an Op suffix
    typedef enum logic [OpWidth-1:0] {
        ldw   = 5'd0,
        add   = 5'd3,
        sub   = 5'd4,
        andOp = 5'd5,
        orOp  = 5'd6,
        shr   = 5'd7,
        shl   = 5'd8,
        neg   = 5'd9,
        notOp = 5'd10,
        outp  = 5'd11
    } opcodeT;

    typedef enum logic [2:0] {
        srcNone = 3'd0, // bus idles at zero
        srcPc   = 3'd1,
        srcMdr  = 3'd2,
        srcZLow = 3'd3,
        srcGpr  = 3'd4
    } busSrcT;

    typedef enum logic [2:0] {
        idle, t0, t1, t2, t3, t4, t5
    } stepT;

    typedef struct packed {
        busSrcT busSrc;
        regIdxT regSel;
        logic   marLoad;
        logic   mdrLoad;
        logic   irLoad;
        logic   yLoad;
        logic   zLoad;
        logic   pcLoad;
        logic   gprLoad;
        logic   outLoad;
        logic   incPc;   // alu forms bus plus one instead of aluOp
        logic   memRead; // mdr takes memory data instead of the bus
        opcodeT aluOp;
    } ctrlT;

endpackage

`default_nettype wire

/* cpuTop.sv */
`default_nettype none

module cpuTop
    import cpuPkg::*;
(
    input  logic Clock,
    input  logic rstN,
    input  logic start,
    input  wordT memData,
    output wordT memAddr,
    output logic memRead,
    output logic done,
    output wordT outPort
);

    ctrlT ctrl;
    wordT irWord;

    controlSequencer uSequencer (
        .Clock  (Clock),
        .rstN   (rstN),
        .start  (start),
        .irWord (irWord),
        .ctrl   (ctrl),
        .done   (done)
    );

    dataPath uDataPath (
        .Clock   (Clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .memData (memData),
        .memAddr (memAddr),
        .irWord  (irWord),
        .outPort (outPort)
    );

    assign memRead = ctrl.memRead; // read level for the memory port

endmodule

`default_nettype wire

/* dataPath.sv */
`default_nettype none

module dataPath
    import cpuPkg::*;
(
    input  logic Clock,
    input  logic rstN,
    input  ctrlT ctrl,
    input  wordT memData,
    output wordT memAddr,
    output wordT irWord,
    output wordT outPort
);

    wordT bus;
    wordT regOut;
    wordT aluLow;
    wordT pc;
    wordT ir;
    wordT mar;
    wordT mdr;
    wordT yReg;
    wordT zLo;

    regFile uRegFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .regSel  (ctrl.regSel),
        .gprLoad (ctrl.gprLoad),
        .busIn   (bus),
        .regOut  (regOut)
    );

    busMux uBusMux (
        .busSrc (ctrl.busSrc),
        .pc     (pc),
        .mdr    (mdr),
        .zLow   (zLo),
        .gpr    (regOut),
        .bus    (bus)
    );

    // second operand always comes straight off the bus
    alu uAlu (
        .aluOp (ctrl.aluOp),
        .incPc (ctrl.incPc),
        .y     (yReg),
        .b     (bus),
        .zHigh (),
        .zLow  (aluLow)
    );

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            ir      <= '0;
            mar     <= '0;
            outPort <= '0;
        end else begin
            if (ctrl.pcLoad)  pc      <= bus;
            if (ctrl.irLoad)  ir      <= bus;
            if (ctrl.marLoad) mar     <= bus;
            if (ctrl.outLoad) outPort <= bus;
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.mdrLoad) mdr <= ctrl.memRead ? memData : bus; // memory read or bus copy
        if (ctrl.yLoad)   yReg <= bus;
        if (ctrl.zLoad)   zLo <= aluLow;
    end

    assign memAddr = mar;
    assign irWord  = ir;

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  logic   Clock,
    input  logic   rstN,
    input  regIdxT regSel,
    input  logic   gprLoad,
    input  wordT   busIn,
    output wordT   regOut
);

    wordT regs [NumRegs];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (gprLoad) begin
            regs[regSel] <= busIn; // write from the shared bus
        end
    end

    // same select drives the read, the sequencer never needs two at once
    assign regOut = regs[regSel];

endmodule

`default_nettype wire

/* tb.f */
cpuPkg.sv
regFile.sv
busMux.sv
alu.sv
dataPath.sv
controlSequencer.sv
cpuTop.sv
tbCpuTop.sv

/* tbCpuTop.sv */
`default_nettype none

module tbCpuTop
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ResetCycles = 16;
    localparam int NumInstr    = 29; // every instruction issued below
    localparam int Margin      = 64; // idle gaps between instructions plus the idle check
    localparam int MaxCycles   = NumInstr * 6 + ResetCycles + Margin;
    localparam int MemWords    = 64;

    logic  Clock;
    logic  rstN;
    logic  start;
    wordT  memData;
    wordT  memAddr;
    logic  memRead;
    logic  done;
    wordT  outPort;

    wordT  mem [MemWords];
    int    wrPtr;      // next free memory word, also where pc fetches next
    int    cycleCount;
    string testName;

    cpuTop u_dut (
        .Clock   (Clock),
        .rstN    (rstN),
        .start   (start),
        .memData (memData),
        .memAddr (memAddr),
        .memRead (memRead),
        .done    (done),
        .outPort (outPort)
    );

    assign memData = mem[memAddr[5:0]]; // combinational read port

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge Clock);
            cycleCount++;
            if (cycleCount > MaxCycles) begin
                abortRun($sformatf("timeout: the tests did not finish within %0d cycles",
                                   MaxCycles));
            end
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string what, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: [%s] %s expected %h actual %h",
                               testName, what, expected, actual));
        end
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: [%s] %s expected %b actual %b",
                               testName, what, expected, actual));
        end
    endtask

    // opcode, ra, rb, rc from the top, rest of the word unused
    function automatic wordT encode(opcodeT op, regIdxT ra, regIdxT rb, regIdxT rc);
        return {op, ra, rb, rc, 15'b0};
    endfunction

    // start one instruction sitting at addr and follow it to done
    task automatic runInstr(input wordT addr, input logic isLdw, input logic pokeBusy);
        int   cycles;
        logic seenDone;
        cycles = 0;
        seenDone = 1'b0;
        start = 1'b1;
        @(posedge Clock); // edge 0, start accepted
        #1;
        start = 1'b0;
        while (!seenDone) begin
            @(negedge Clock);
            cycles++;
            if (cycles == 2) checkWord("fetch address", addr, memAddr);
            if (isLdw && cycles == 5) checkWord("inline word address", addr + 1, memAddr);
            checkBit($sformatf("memRead in cycle %0d", cycles),
                     (cycles == 2) || (isLdw && cycles == 5), memRead);
            if (done) begin
                seenDone = 1'b1;
            end else if (cycles >= 6) begin
                abortRun($sformatf("%s: done did not arrive within six cycles", testName));
            end
            @(posedge Clock);
            #1;
            start = pokeBusy && (cycles == 2); // stray start while busy
        end
        checkWord("cycles from start to done", wordT'(6), wordT'(cycles));
    endtask

    task automatic execInstr(input wordT instr);
        mem[wrPtr] = instr;
        wrPtr++;
        runInstr(wordT'(wrPtr - 1), 1'b0, 1'b0);
    endtask

    task automatic loadWord(input regIdxT r, input wordT value, input logic pokeBusy);
        mem[wrPtr]     = encode(ldw, r, '0, '0);
        mem[wrPtr + 1] = value; // inline word right after the ldw
        wrPtr += 2;
        runInstr(wordT'(wrPtr - 2), 1'b1, pokeBusy);
    endtask

    task automatic expectReg(input regIdxT r, input wordT expected);
        execInstr(encode(outp, r, '0, '0));
        checkWord($sformatf("R%0d via outp", r), expected, outPort);
    endtask

    task automatic testReset();
        testName = "reset";
        checkBit("done", 1'b0, done);
        checkBit("memRead", 1'b0, memRead);
        checkWord("outPort", '0, outPort);
        expectReg(4'd5, '0);
    endtask

    task automatic testLoads();
        testName = "ldw";
        loadWord(4'd2, 32'h12, 1'b0);
        loadWord(4'd3, 32'h14, 1'b0);
        loadWord(4'd1, 32'h18, 1'b0);
        expectReg(4'd2, 32'h12);
        expectReg(4'd3, 32'h14);
        expectReg(4'd1, 32'h18);
    endtask

    task automatic testReferenceSub();
        testName = "sub R1, R2, R3";
        execInstr(32'h20918000);
        expectReg(4'd1, 32'hFFFF_FFFE);
    endtask

    task automatic testLogicArith();
        wordT a;
        wordT b;
        testName = "alu ops";
        a = $urandom;
        b = $urandom;
        loadWord(4'd6, a, 1'b0);
        loadWord(4'd7, b, 1'b0);
        execInstr(encode(add, 4'd8, 4'd6, 4'd7));
        expectReg(4'd8, a + b);
        execInstr(encode(andOp, 4'd8, 4'd6, 4'd7));
        expectReg(4'd8, a & b);
        execInstr(encode(orOp, 4'd8, 4'd6, 4'd7));
        expectReg(4'd8, a | b);
        execInstr(encode(neg, 4'd8, 4'd6, 4'd7)); // only rc counts
        expectReg(4'd8, ~b + 32'd1);
        execInstr(encode(notOp, 4'd8, 4'd6, 4'd7));
        expectReg(4'd8, ~b);
    endtask

    task automatic testShifts();
        wordT value;
        wordT amount;
        testName = "shifts";
        value  = $urandom;
        amount = $urandom; // upper bits must be ignored
        loadWord(4'd9, value, 1'b0);
        loadWord(4'd10, amount, 1'b0);
        execInstr(encode(shl, 4'd11, 4'd9, 4'd10));
        expectReg(4'd11, value << amount[4:0]);
        execInstr(encode(shr, 4'd11, 4'd9, 4'd10));
        expectReg(4'd11, value >> amount[4:0]);
    endtask

    task automatic testBusyStart();
        wordT value;
        testName = "start while busy";
        value = $urandom;
        loadWord(4'd12, value, 1'b1);
        repeat (8) begin
            @(negedge Clock);
            checkBit("done after the instruction", 1'b0, done);
            checkBit("memRead after the instruction", 1'b0, memRead);
        end
        @(posedge Clock);
        #1;
        expectReg(4'd12, value);
    endtask

    initial begin
        int unsigned seedInit;
        seedInit = $urandom(32'he31c);
        rstN  = 1'b0;
        start = 1'b0;
        wrPtr = 0;
        testName = "setup";
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = 32'h5A00_0000 ^ (i << 12) ^ (i * 32'h0001_0101);
        end
        repeat (ResetCycles) @(posedge Clock);
        #1;
        rstN = 1'b1;
        testReset();
        testLoads();
        testReferenceSub();
        testLogicArith();
        testShifts();
        testBusyStart();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
